//--- data_pkg.sv
package data_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int unsigned OPERAND_W  = 16;              // one input operand
    localparam int unsigned SUM_W      = OPERAND_W + 1;   // sum plus carry
    localparam int unsigned SDIFF_W    = OPERAND_W + 1;   // a - b, two's complement
    localparam int unsigned ABSDIFF_W  = OPERAND_W;       // |a - b| always fits
    localparam int unsigned DIFF_RES_W = ABSDIFF_W + 1;   // magnitude + lt flag
    localparam int unsigned RESULT_W   = SUM_W + DIFF_RES_W;

    // ------------------------------
    // plain vector types
    // ------------------------------
    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [SUM_W-1:0]     sum_t;
    typedef logic [SDIFF_W-1:0]   sdiff_t;     // msb is the sign
    typedef logic [ABSDIFF_W-1:0] absdiff_t;

    // input item, a in the upper half
    typedef struct packed {
        operand_t a;
        operand_t b;
    } pair_t;

    // diff lane output
    typedef struct packed {
        absdiff_t mag;   // |a - b|
        logic     lt;    // a < b
    } diff_res_t;

    // joined result, 34 bits
    typedef struct packed {
        sum_t     sum;
        absdiff_t mag;
        logic     lt;
    } result_t;

endpackage

//--- ctrl_pkg.sv
package ctrl_pkg;

    // spill cell control states
    typedef enum logic [2:0] {
        RESET,            // one idle cycle after reset or flush
        NO_DATA,          // both registers empty
        A_FULL,           // one item, held in A
        B_FULL,           // one item, held in B
        AB_FULL_SEL_A,    // both full, A is older
        AB_FULL_SEL_B     // both full, B is older
    } spill_state_t;

    // which fork outputs already took the current pair
    typedef struct packed {
        logic sum_taken;
        logic diff_taken;
    } fork_taken_t;

endpackage

//--- spill_cell_cu.sv
`timescale 1ns/1ps

module spill_cell_cu (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic valid_i,     // upstream has data
    input  logic ready_i,     // downstream takes data
    output logic valid_o,
    output logic ready_o,
    output logic a_en_o,      // load register A
    output logic b_en_o,      // load register B (spill)
    output logic b_sel_o      // output mux, 1 = B
);

    import ctrl_pkg::*;

    spill_state_t state_q, state_d;

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            RESET: state_d = NO_DATA;
            NO_DATA: begin
                if (valid_i) state_d = A_FULL;   // first item goes to A
            end
            A_FULL: begin
                // new item lands in B, A may leave at the same edge
                if (valid_i) state_d = ready_i ? B_FULL : AB_FULL_SEL_A;
                else if (ready_i) state_d = NO_DATA;
            end
            B_FULL: begin
                if (valid_i) state_d = ready_i ? A_FULL : AB_FULL_SEL_B;
                else if (ready_i) state_d = NO_DATA;
            end
            AB_FULL_SEL_A: begin
                if (ready_i) state_d = B_FULL;   // A drained, B now the older one
            end
            AB_FULL_SEL_B: begin
                if (ready_i) state_d = A_FULL;
            end
            default: state_d = RESET;
        endcase
    end

    // ------------------------------
    // outputs, enables are mealy
    // ------------------------------
    always_comb begin
        valid_o = 1'b0;
        ready_o = 1'b0;
        a_en_o  = 1'b0;
        b_en_o  = 1'b0;
        b_sel_o = 1'b0;
        case (state_q)
            NO_DATA: begin
                ready_o = !flush_i;
                a_en_o  = valid_i;    // capture into A
            end
            A_FULL: begin
                valid_o = 1'b1;       // A on the output
                ready_o = !flush_i;
                b_en_o  = valid_i;    // next item to B
            end
            B_FULL: begin
                valid_o = 1'b1;
                ready_o = !flush_i;
                a_en_o  = valid_i;
                b_sel_o = 1'b1;
            end
            AB_FULL_SEL_A: begin
                valid_o = 1'b1;       // stalled, hold both
            end
            AB_FULL_SEL_B: begin
                valid_o = 1'b1;
                b_sel_o = 1'b1;
            end
            default: ;                // RESET: all low
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RESET;
        end else if (flush_i) begin
            state_q <= RESET;         // sync flush drops both items
        end else begin
            state_q <= state_d;
        end
    end

    // a loaded register shows up as full, so A and B never load together
    a_load_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (a_en_o && !flush_i) |=> (state_q inside {A_FULL, AB_FULL_SEL_B}));

    b_load_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (b_en_o && !flush_i) |=> (state_q inside {B_FULL, AB_FULL_SEL_A}));

    // a cell that fills under a stall stops accepting
    full_stall_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && !ready_i && valid_i && ready_o) |=> !ready_o);

endmodule

//--- spill_cell.sv
`timescale 1ns/1ps

module spill_cell #(
    parameter int unsigned DATA_W = 16
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              valid_i,
    input  logic              ready_i,
    input  logic [DATA_W-1:0] data_i,
    output logic              valid_o,
    output logic              ready_o,
    output logic [DATA_W-1:0] data_o
);

    logic              a_en, b_en, b_sel;
    logic [DATA_W-1:0] a_q, b_q;     // main and spill registers

    spill_cell_cu u_cu (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (valid_i),
        .ready_i (ready_i),
        .valid_o (valid_o),
        .ready_o (ready_o),
        .a_en_o  (a_en),
        .b_en_o  (b_en),
        .b_sel_o (b_sel)
    );

    // payload only, occupancy lives in the cu
    always_ff @(posedge clk_i) begin
        if (a_en) a_q <= data_i;
        if (b_en) b_q <= data_i;
    end

    assign data_o = b_sel ? b_q : a_q;   // older item out

    // stalled item stays put until taken
    hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && !ready_i && !flush_i) |=> (valid_o && $stable(data_o)));

endmodule

//--- elastic_fork.sv
`timescale 1ns/1ps

module elastic_fork (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            flush_i,
    input  logic            valid_i,
    input  logic            sum_ready_i,
    input  logic            diff_ready_i,
    input  data_pkg::pair_t pair_i,
    output logic            ready_o,
    output logic            sum_valid_o,
    output logic            diff_valid_o,
    output data_pkg::pair_t pair_o
);

    import ctrl_pkg::*;

    fork_taken_t taken_q;
    logic        sum_done, diff_done;   // lane has it or takes it now

    // offer only to lanes still missing this pair
    assign sum_valid_o  = valid_i && !taken_q.sum_taken;
    assign diff_valid_o = valid_i && !taken_q.diff_taken;

    assign sum_done  = taken_q.sum_taken || sum_ready_i;
    assign diff_done = taken_q.diff_taken || diff_ready_i;
    assign ready_o   = sum_done && diff_done;    // last lane acks upstream
    assign pair_o    = pair_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            taken_q <= '0;
        end else if (flush_i || (valid_i && ready_o)) begin
            taken_q <= '0;                        // pair fully delivered
        end else begin
            taken_q.sum_taken  <= taken_q.sum_taken || (sum_valid_o && sum_ready_i);
            taken_q.diff_taken <= taken_q.diff_taken || (diff_valid_o && diff_ready_i);
        end
    end

    // both set means the input ack was missed
    taken_excl_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(taken_q.sum_taken && taken_q.diff_taken));

endmodule

//--- sum_lane.sv
`timescale 1ns/1ps

module sum_lane (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            flush_i,
    input  logic            valid_i,
    input  logic            ready_i,
    input  data_pkg::pair_t pair_i,
    output logic            ready_o,
    output logic            valid_o,
    output data_pkg::sum_t  sum_o
);

    import data_pkg::*;

    sum_t sum_d;

    assign sum_d = {1'b0, pair_i.a} + {1'b0, pair_i.b};   // carry kept in msb

    spill_cell #(.DATA_W(SUM_W)) u_sum_cell (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (valid_i),
        .ready_i (ready_i),
        .data_i  (sum_d),
        .valid_o (valid_o),
        .ready_o (ready_o),
        .data_o  (sum_o)
    );

endmodule

//--- diff_lane.sv
`timescale 1ns/1ps

module diff_lane (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                valid_i,
    input  logic                ready_i,
    input  data_pkg::pair_t     pair_i,
    output logic                ready_o,
    output logic                valid_o,
    output data_pkg::diff_res_t diff_o
);

    import data_pkg::*;

    sdiff_t    sdiff_d, sdiff_q, sdiff_neg;
    logic      mid_valid, mid_ready;      // stage 1 to stage 2
    diff_res_t res_d;

    assign sdiff_d = {1'b0, pair_i.a} - {1'b0, pair_i.b};

    // ------------------------------
    // stage 1, signed difference
    // ------------------------------
    spill_cell #(.DATA_W(SDIFF_W)) u_sdiff_cell (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (valid_i),
        .ready_i (mid_ready),
        .data_i  (sdiff_d),
        .valid_o (mid_valid),
        .ready_o (ready_o),
        .data_o  (sdiff_q)
    );

    // ------------------------------
    // stage 2, sign and magnitude
    // ------------------------------
    assign sdiff_neg = '0 - sdiff_q;                 // b - a when negative
    assign res_d.lt  = sdiff_q[SDIFF_W-1];
    assign res_d.mag = res_d.lt ? sdiff_neg[ABSDIFF_W-1:0] : sdiff_q[ABSDIFF_W-1:0];

    spill_cell #(.DATA_W(DIFF_RES_W)) u_abs_cell (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (mid_valid),
        .ready_i (ready_i),
        .data_i  (res_d),
        .valid_o (valid_o),
        .ready_o (mid_ready),
        .data_o  (diff_o)
    );

endmodule

//--- result_join.sv
`timescale 1ns/1ps

module result_join (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                sum_valid_i,
    input  logic                diff_valid_i,
    input  logic                ready_i,
    input  data_pkg::sum_t      sum_i,
    input  data_pkg::diff_res_t diff_i,
    output logic                sum_ready_o,
    output logic                diff_ready_o,
    output logic                valid_o,
    output data_pkg::result_t   result_o
);

    import data_pkg::*;

    logic    both_valid, cell_ready;
    result_t res_d;

    assign both_valid = sum_valid_i && diff_valid_i;   // wait for the slower lane

    // ack each lane only when the partner is there too
    assign sum_ready_o  = cell_ready && diff_valid_i;
    assign diff_ready_o = cell_ready && sum_valid_i;

    assign res_d = {sum_i, diff_i.mag, diff_i.lt};

    spill_cell #(.DATA_W(RESULT_W)) u_out_cell (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (both_valid),
        .ready_i (ready_i),
        .data_i  (res_d),
        .valid_o (valid_o),
        .ready_o (cell_ready),
        .data_o  (result_o)
    );

endmodule

//--- pair_stream_top.sv
`timescale 1ns/1ps

module pair_stream_top (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              valid_i,
    input  logic              ready_i,
    input  data_pkg::pair_t   pair_i,
    output logic              ready_o,
    output logic              valid_o,
    output data_pkg::result_t result_o
);

    import data_pkg::*;

    pair_t     lane_pair;                   // fork copy for both lanes
    logic      fs_valid, fs_ready;          // fork to sum lane
    logic      fd_valid, fd_ready;          // fork to diff lane
    logic      sj_valid, sj_ready;          // sum lane to join
    logic      dj_valid, dj_ready;          // diff lane to join
    sum_t      sum_w;
    diff_res_t diff_w;

    elastic_fork u_fork (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .valid_i      (valid_i),
        .sum_ready_i  (fs_ready),
        .diff_ready_i (fd_ready),
        .pair_i       (pair_i),
        .ready_o      (ready_o),
        .sum_valid_o  (fs_valid),
        .diff_valid_o (fd_valid),
        .pair_o       (lane_pair)
    );

    sum_lane u_sum (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (fs_valid),
        .ready_i (sj_ready),
        .pair_i  (lane_pair),
        .ready_o (fs_ready),
        .valid_o (sj_valid),
        .sum_o   (sum_w)
    );

    diff_lane u_diff (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (fd_valid),
        .ready_i (dj_ready),
        .pair_i  (lane_pair),
        .ready_o (fd_ready),
        .valid_o (dj_valid),
        .diff_o  (diff_w)
    );

    result_join u_join (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .sum_valid_i  (sj_valid),
        .diff_valid_i (dj_valid),
        .ready_i      (ready_i),
        .sum_i        (sum_w),
        .diff_i       (diff_w),
        .sum_ready_o  (sj_ready),
        .diff_ready_o (dj_ready),
        .valid_o      (valid_o),
        .result_o     (result_o)
    );

endmodule

//--- tb_pair_stream.sv
`timescale 1ns/1ps

module tb_pair_stream;

    import data_pkg::*;

    localparam int NUM_VEC   = 28;
    localparam int WORDS     = 5;                  // a, b, sum, mag, lt
    localparam int RST_CYC   = 10;
    localparam int MAX_CYC   = NUM_VEC * 20 + RST_CYC;
    localparam int LATENCY   = 3;

    logic    clk_i, rst_n_i, flush_i, valid_i, ready_i;
    pair_t   pair_i;
    logic    ready_o, valid_o;
    result_t result_o;

    logic [19:0] vec_mem [0:NUM_VEC*WORDS-1];
    int          exp_q[$];                         // vector index per item in flight
    int          acc_q[$];                         // accept cycle per item
    int          cur_idx, cycle_cnt, ready_mode, out_count;
    int          rnd;
    integer      seed;
    bit          lat_check, hold_valid;
    result_t     held;

    pair_stream_top u_dut (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .valid_i  (valid_i),
        .ready_i  (ready_i),
        .pair_i   (pair_i),
        .ready_o  (ready_o),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;   // 8 ns period
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // ------------------------------
    // downstream ready, 0 high, 1 random, 2 low
    // ------------------------------
    always @(posedge clk_i) begin
        rnd = $random(seed);
        case (ready_mode)
            0:       ready_i <= 1'b1;
            1:       ready_i <= rnd[0];
            default: ready_i <= 1'b0;
        endcase
    end

    // ------------------------------
    // monitor, samples pre-edge values
    // ------------------------------
    always @(posedge clk_i) begin
        int idx;
        int acc;
        cycle_cnt++;
        if (hold_valid) begin                      // stalled result must not move
            check_value(64'(valid_o), 64'd1, "valid_o dropped while stalled");
            check_value(64'(result_o), 64'(held), "result_o moved while stalled");
            hold_valid = 1'b0;
        end
        if (valid_o && !ready_i && !flush_i) begin
            hold_valid = 1'b1;
            held       = result_o;
        end
        if (valid_o && ready_i) begin
            if (exp_q.size() == 0) begin
                $display("Output appeared at %0t with no item pending", $time);
                $display(">>> FAIL");
                $fatal(1);
            end
            idx = exp_q.pop_front();
            acc = acc_q.pop_front();
            check_value(64'(result_o.sum), 64'(vec_mem[idx*WORDS+2][16:0]), "sum");
            check_value(64'(result_o.mag), 64'(vec_mem[idx*WORDS+3][15:0]), "abs diff");
            check_value(64'(result_o.lt), 64'(vec_mem[idx*WORDS+4][0]), "lt flag");
            if (lat_check) begin
                check_value(64'(cycle_cnt - acc), 64'(LATENCY), "latency");
                lat_check = 1'b0;                  // first result of an idle pipe
            end
            out_count++;
        end
        if (valid_i && ready_o) begin              // input taken at this edge
            exp_q.push_back(cur_idx);
            acc_q.push_back(cycle_cnt);
        end
        if (flush_i) begin                         // in-flight items are dropped
            exp_q.delete();
            acc_q.delete();
            hold_valid = 1'b0;
        end
    end

    // offer one vector, return at its accept edge
    task automatic send_item(input int idx);
        valid_i <= 1'b1;
        pair_i  <= {vec_mem[idx*WORDS][15:0], vec_mem[idx*WORDS+1][15:0]};
        cur_idx <= idx;
        @(posedge clk_i);
        while (!ready_o) @(posedge clk_i);
    endtask

    task automatic send_range(input int first, input int last);
        for (int i = first; i <= last; i++) send_item(i);
        valid_i <= 1'b0;
    endtask

    task automatic wait_drained();
        do @(posedge clk_i); while (exp_q.size() != 0);
    endtask

    // watchdog
    initial begin
        repeat (MAX_CYC) @(posedge clk_i);
        $display("Run timed out after %0d cycles", MAX_CYC);
        $display(">>> FAIL");
        $fatal(1);
    end

    initial begin
        rst_n_i    = 1'b0;
        flush_i    = 1'b0;
        valid_i    = 1'b0;
        ready_i    = 1'b0;
        pair_i     = '0;
        cur_idx    = 0;
        cycle_cnt  = 0;
        out_count  = 0;
        ready_mode = 0;
        lat_check  = 1'b0;
        hold_valid = 1'b0;
        seed       = 32'h7e33;
        $readmemh("pair_vectors.txt", vec_mem);

        // ------------------------------
        // reset
        // ------------------------------
        repeat (RST_CYC) begin
            @(posedge clk_i);
            check_value(64'(valid_o), 64'd0, "valid_o in reset");
            check_value(64'(ready_o), 64'd0, "ready_o in reset");
        end
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        check_value(64'(ready_o), 64'd0, "ready_o first cycle after reset");
        check_value(64'(valid_o), 64'd0, "valid_o first cycle after reset");
        @(posedge clk_i);
        check_value(64'(ready_o), 64'd1, "ready_o second cycle after reset");

        // full rate, latency of the first result
        lat_check = 1'b1;
        send_range(0, 7);
        wait_drained();

        // random back-pressure
        ready_mode = 1;
        send_range(8, 19);
        wait_drained();

        // ------------------------------
        // flush with items in flight
        // ------------------------------
        ready_mode = 2;
        send_range(20, 23);
        repeat (3) @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        @(posedge clk_i);
        check_value(64'(valid_o), 64'd0, "valid_o after flush");
        check_value(64'(ready_o), 64'd0, "ready_o right after flush");
        @(posedge clk_i);
        check_value(64'(ready_o), 64'd1, "ready_o two cycles after flush");
        ready_mode = 1;
        send_range(24, 27);
        wait_drained();
        repeat (10) @(posedge clk_i);              // stray pre-flush output would fail here

        check_value(64'(out_count), 64'd24, "result count");
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- pair_vectors.txt
// columns: a b sum abs_diff lt, all hex
// sum is 17 bits, lt is 1 when a < b
0000 0000 00000 0000 0
0001 0002 00003 0001 1
ffff ffff 1fffe 0000 0
ffff 0000 0ffff ffff 0
0000 ffff 0ffff ffff 1
1234 0234 01468 1000 0
8000 8000 10000 0000 0
00ff 0100 001ff 0001 1
abcd 1234 0be01 9999 0
1234 abcd 0be01 9999 1
7fff 8000 0ffff 0001 1
8000 7fff 0ffff 0001 0
0010 0020 00030 0010 1
5555 aaaa 0ffff 5555 1
aaaa 5555 0ffff 5555 0
c000 4000 10000 8000 0
4000 c000 10000 8000 1
0100 0001 00101 00ff 0
fffe 0001 0ffff fffd 0
0001 fffe 0ffff fffd 1
1111 2222 03333 1111 1
3333 1111 04444 2222 0
9000 9000 12000 0000 0
0f0f f0f0 0ffff e1e1 1
2468 1357 037bf 1111 0
1357 2468 037bf 1111 1
e000 3000 11000 b000 0
0abc 0abc 01578 0000 0

//--- list.f
data_pkg.sv
ctrl_pkg.sv
spill_cell_cu.sv
spill_cell.sv
elastic_fork.sv
sum_lane.sv
diff_lane.sv
result_join.sv
pair_stream_top.sv
tb_pair_stream.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_pair_stream
FILELIST  := list.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) pair_vectors.txt
	./$(BIN)

clean:
	rm -rf obj_dir
